// File: list.f
mbox_bus_pkg.sv
mbox_proto_pkg.sv
mbox_req_decode.sv
mbox_fsm.sv
mbox_buffer.sv
mbox_rsp.sv
mbox_top.sv
tb_mbox.sv

// File: mbox_buffer.sv
/*
 mailbox data buffer
 internal word array with self-advancing write and read pointers and a
 dataout register that is refilled one cycle after the read pointer moves
*/

`timescale 1ns/100ps

module mbox_buffer #(
    parameter int MBOX_DEPTH = 64
) (
    input  logic                    clk,
    input  logic                    rst_b,
    input  mbox_bus_pkg::bus_data_t wdata,
    input  logic                    buf_we,
    input  logic                    inc_rdptr,
    input  logic                    rst_wrptr,
    input  logic                    rst_rdptr,
    output mbox_bus_pkg::bus_data_t dataout,
    output logic                    prefetch_busy
);
    import mbox_bus_pkg::*;

    localparam int PTR_W = $clog2(MBOX_DEPTH);

    // index of one word in the array
    typedef logic [PTR_W-1:0] buf_ptr_t;

    localparam buf_ptr_t LAST_PTR = buf_ptr_t'(MBOX_DEPTH - 1);

    bus_data_t mem [MBOX_DEPTH];
    buf_ptr_t  wrptr;
    buf_ptr_t  rdptr;

    // pointers wrap at the array depth, which need not be a power of two
    function automatic buf_ptr_t ptr_inc(input buf_ptr_t ptr);
        ptr_inc = (ptr == LAST_PTR) ? '0 : buf_ptr_t'(ptr + 1'b1);
    endfunction

    // each datain write lands at the write pointer and moves it on
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wrptr <= '0;
        end else if (rst_wrptr) begin
            wrptr <= '0;
        end else if (buf_we) begin
            wrptr <= ptr_inc(wrptr);
        end
    end

    // the read pointer always names the word that dataout should show
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rdptr <= '0;
        end else if (rst_rdptr) begin
            rdptr <= '0;
        end else if (inc_rdptr) begin
            rdptr <= ptr_inc(rdptr);
        end
    end

    // the refill is pending during the cycle after any read pointer update
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            prefetch_busy <= 1'b0;
        end else begin
            prefetch_busy <= inc_rdptr | rst_rdptr;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_we) begin
            mem[wrptr] <= wdata;
        end
        // fetch the word under the updated read pointer
        if (prefetch_busy) begin
            dataout <= mem[rdptr];
        end
    end

endmodule

// File: mbox_bus_pkg.sv
/*
 mailbox bus definitions
 word, address and user widths of the requester bus, the request struct
 and the byte offsets of the mailbox register map
*/

package mbox_bus_pkg;

    // widths of the requester bus
    localparam int BUS_DATA_W  = 32;
    localparam int BUS_ADDR_W  = 8;
    localparam int MBOX_USER_W = 8;

    // one data word, both on the bus and inside the buffer
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    // byte address inside the mailbox window
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

    // user id that comes with every soc request
    typedef logic [MBOX_USER_W-1:0] mbox_user_t;

    // a single request as the requester presents it
    // soc_req tells a soc access apart from a uc access
    typedef struct packed {
        logic       write;
        logic       soc_req;
        mbox_user_t user;
        bus_addr_t  addr;
        bus_data_t  wdata;
    } mbox_req_t;

    // register map, one word per register
    localparam bus_addr_t LOCK_OFS    = 8'h00;
    localparam bus_addr_t USER_OFS    = 8'h04;
    localparam bus_addr_t CMD_OFS     = 8'h08;
    localparam bus_addr_t DLEN_OFS    = 8'h0C;
    localparam bus_addr_t DATAIN_OFS  = 8'h10;
    localparam bus_addr_t DATAOUT_OFS = 8'h14;
    localparam bus_addr_t EXECUTE_OFS = 8'h18;
    localparam bus_addr_t STATUS_OFS  = 8'h1C;

    // anything above this offset is outside the map
    localparam bus_addr_t LAST_OFS    = STATUS_OFS;

endpackage

// File: mbox_fsm.sv
/*
 mailbox protocol engine
 owns the lock and the identity of its holder, keeps the command, length,
 execute and status registers and runs the state machine that hands the
 buffer from the sender to the receiver and back
*/

`timescale 1ns/100ps

module mbox_fsm (
    input  logic                        clk,
    input  logic                        rst_b,
    input  mbox_proto_pkg::reg_acc_t    acc,
    output mbox_proto_pkg::mbox_state_e state,
    output logic                        valid_user,
    output logic                        buf_we,
    output logic                        inc_rdptr,
    output logic                        rst_wrptr,
    output logic                        rst_rdptr,
    output mbox_bus_pkg::bus_data_t     reg_rdata,
    output logic                        uc_mbox_data_avail,
    output logic                        soc_mbox_data_avail
);
    import mbox_bus_pkg::*;
    import mbox_proto_pkg::*;

    mbox_state_e  state_nxt;
    logic         lock;
    logic         soc_has_lock;
    mbox_user_t   lock_user;
    bus_data_t    cmd;
    bus_data_t    dlen;
    logic         execute;
    mbox_status_e status;

    logic in_exec;
    logic rcv_side;
    logic take_lock;
    logic exec_wr;
    logic enter_exec;
    logic unlock;
    logic handback;
    logic swap;

    assign in_exec = (state == MBOX_EXECUTE_UC) || (state == MBOX_EXECUTE_SOC);

    // the uc is trusted unless the soc holds the lock outside of execute uc,
    // a soc request must come from the very user that took the lock
    assign valid_user = lock &
        ((~acc.soc_req & (~soc_has_lock | (state == MBOX_EXECUTE_UC))) |
         ( acc.soc_req & soc_has_lock & (acc.user == lock_user)));

    // the side that is meant to consume the data in the current execute state
    assign rcv_side = ((state == MBOX_EXECUTE_UC) & ~acc.soc_req) |
                      ((state == MBOX_EXECUTE_SOC) & acc.soc_req);

    // reading an unlocked lock register grabs it
    assign take_lock  = acc.rd_lock & ~lock;
    assign exec_wr    = acc.wr_execute & valid_user;
    assign enter_exec = exec_wr & acc.wdata[0] & (state == MBOX_RDY_FOR_DATA);
    assign unlock     = exec_wr & ~acc.wdata[0] & in_exec;

    // once the receiver posts a final status the buffer goes back to the lock holder
    // a swap waits for a cycle without buffer traffic so the pointers stay coherent
    assign handback = (status != CMD_BUSY) & ~(acc.wr_datain | acc.rd_dataout) &
                      (((state == MBOX_EXECUTE_UC) & soc_has_lock) |
                       ((state == MBOX_EXECUTE_SOC) & ~soc_has_lock));
    assign swap = handback & ~unlock;

    // sender fills the buffer before execute, the receiver may answer after it
    assign buf_we    = acc.wr_datain & valid_user & ((state == MBOX_RDY_FOR_DATA) | rcv_side);
    assign inc_rdptr = acc.rd_dataout & valid_user & rcv_side;
    // entering an execute state restarts reading and prefetches word zero
    assign rst_wrptr = enter_exec | unlock | swap;
    assign rst_rdptr = enter_exec | swap;

    assign uc_mbox_data_avail  = (state == MBOX_EXECUTE_UC);
    assign soc_mbox_data_avail = (state == MBOX_EXECUTE_SOC);

    always_comb begin
        state_nxt = state;
        unique case (state)
            MBOX_IDLE: begin
                if (take_lock) state_nxt = MBOX_RDY_FOR_CMD;
            end
            MBOX_RDY_FOR_CMD: begin
                if (acc.wr_cmd & valid_user) state_nxt = MBOX_RDY_FOR_DLEN;
            end
            MBOX_RDY_FOR_DLEN: begin
                if (acc.wr_dlen & valid_user) state_nxt = MBOX_RDY_FOR_DATA;
            end
            MBOX_RDY_FOR_DATA: begin
                // a soc sender talks to the uc and the other way round
                if (enter_exec) state_nxt = soc_has_lock ? MBOX_EXECUTE_UC : MBOX_EXECUTE_SOC;
            end
            MBOX_EXECUTE_UC: begin
                if (unlock) state_nxt = MBOX_IDLE;
                else if (swap) state_nxt = MBOX_EXECUTE_SOC;
            end
            MBOX_EXECUTE_SOC: begin
                if (unlock) state_nxt = MBOX_IDLE;
                else if (swap) state_nxt = MBOX_EXECUTE_UC;
            end
            default: state_nxt = MBOX_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state        <= MBOX_IDLE;
            lock         <= 1'b0;
            soc_has_lock <= 1'b0;
            lock_user    <= '0;
            cmd          <= '0;
            dlen         <= '0;
            execute      <= 1'b0;
            status       <= CMD_BUSY;
        end else begin
            state <= state_nxt;
            // remember who took the lock, it decides the execute direction
            if (take_lock) begin
                lock         <= 1'b1;
                soc_has_lock <= acc.soc_req;
                lock_user    <= acc.user;
            end else if (unlock) begin
                lock <= 1'b0;
            end
            if (acc.wr_cmd & valid_user) cmd <= acc.wdata;
            if (acc.wr_dlen & valid_user) dlen <= acc.wdata;
            if (exec_wr) execute <= acc.wdata[0];
            // status is cleared for the next command when the mailbox is released
            if (unlock) status <= CMD_BUSY;
            else if (acc.wr_status & valid_user & rcv_side) status <= mbox_status_e'(acc.wdata[1:0]);
        end
    end

    // register read values, dataout is filled in by the response stage
    always_comb begin
        reg_rdata = '0;
        case (acc.addr)
            LOCK_OFS:    reg_rdata[0]   = lock;
            USER_OFS:    reg_rdata[7:0] = lock_user;
            CMD_OFS:     reg_rdata      = cmd;
            DLEN_OFS:    reg_rdata      = dlen;
            EXECUTE_OFS: reg_rdata[0]   = execute;
            STATUS_OFS:  reg_rdata[4:0] = {state, status};
            default:     reg_rdata      = '0;
        endcase
    end

    // the buffer must never see a pointer move and a restart together
    ptr_move_vs_reset: assert property (@(posedge clk) disable iff (!rst_b)
        !((buf_we && rst_wrptr) || (inc_rdptr && rst_rdptr)))
        else $error("buffer pointer moved and reset in the same cycle");

endmodule

// File: mbox_proto_pkg.sv
/*
 mailbox protocol definitions
 state machine encoding, command status values and the per-access
 strobe bundle that travels from the decode stage to the later stages
*/

package mbox_proto_pkg;

    // protocol states, a requester walks them in this order
    typedef enum logic [2:0] {
        MBOX_IDLE         = 3'd0,
        MBOX_RDY_FOR_CMD  = 3'd1,
        MBOX_RDY_FOR_DLEN = 3'd2,
        MBOX_RDY_FOR_DATA = 3'd3,
        MBOX_EXECUTE_UC   = 3'd4,
        MBOX_EXECUTE_SOC  = 3'd5
    } mbox_state_e;

    // status the receiver writes once it has handled a command
    typedef enum logic [1:0] {
        CMD_BUSY     = 2'd0,
        DATA_READY   = 2'd1,
        CMD_COMPLETE = 2'd2,
        CMD_FAILURE  = 2'd3
    } mbox_status_e;

    // one decoded access, every strobe is a single cycle wide
    // accept is high for any request taken this cycle, the register
    // strobes pick out the accesses that have a side effect
    typedef struct packed {
        logic                    accept;
        logic                    rd_lock;
        logic                    wr_cmd;
        logic                    wr_dlen;
        logic                    wr_datain;
        logic                    rd_dataout;
        logic                    wr_execute;
        logic                    wr_status;
        logic                    bad;
        logic                    soc_req;
        mbox_bus_pkg::mbox_user_t user;
        logic                    write;
        mbox_bus_pkg::bus_addr_t addr;
        mbox_bus_pkg::bus_data_t wdata;
    } reg_acc_t;

endpackage

// File: mbox_req_decode.sv
/*
 mailbox request decode
 turns an accepted request into register access strobes and flags
 accesses that fall off the register map or write a read-only register
*/

`timescale 1ns/100ps

module mbox_req_decode (
    input  logic                     req_dv,
    input  logic                     req_hold,
    input  mbox_bus_pkg::mbox_req_t  req,
    output mbox_proto_pkg::reg_acc_t acc
);
    import mbox_bus_pkg::*;

    logic accept;
    logic on_map;
    logic ro_write;

    // nothing is taken while the prefetch is still filling dataout
    assign accept = req_dv & ~req_hold;

    // registers sit on word boundaries up to the last offset
    assign on_map = (req.addr[1:0] == 2'b00) && (req.addr <= LAST_OFS);

    // lock and dataout are only ever read
    assign ro_write = req.write && ((req.addr == LOCK_OFS) || (req.addr == DATAOUT_OFS));

    always_comb begin
        acc         = '0;
        acc.accept  = accept;
        acc.soc_req = req.soc_req;
        acc.user    = req.user;
        acc.write   = req.write;
        acc.addr    = req.addr;
        acc.wdata   = req.wdata;
        acc.bad     = accept & (~on_map | ro_write);

        // user and status reads have no side effect and get no strobe
        // an address off the map gets no strobe and is flagged through on_map
        case (req.addr)
            LOCK_OFS:    acc.rd_lock    = accept & ~req.write;
            CMD_OFS:     acc.wr_cmd     = accept & req.write;
            DLEN_OFS:    acc.wr_dlen    = accept & req.write;
            DATAIN_OFS:  acc.wr_datain  = accept & req.write;
            DATAOUT_OFS: acc.rd_dataout = accept & ~req.write;
            EXECUTE_OFS: acc.wr_execute = accept & req.write;
            STATUS_OFS:  acc.wr_status  = accept & req.write;
            default:     ;
        endcase
    end

    // the later stages rely on a single register action per access
    always_comb begin
        assert ($onehot0({acc.rd_lock, acc.wr_cmd, acc.wr_dlen, acc.wr_datain,
                          acc.rd_dataout, acc.wr_execute, acc.wr_status}))
            else $error("more than one register strobe for one access");
    end

endmodule

// File: mbox_rsp.sv
/*
 mailbox response stage
 picks dataout or the register value, hides buffer data from the wrong
 requester and registers the read data, its valid and the error strobe
*/

`timescale 1ns/100ps

module mbox_rsp (
    input  logic                        clk,
    input  logic                        rst_b,
    input  mbox_proto_pkg::reg_acc_t    acc,
    input  logic                        valid_user,
    input  mbox_proto_pkg::mbox_state_e state,
    input  mbox_bus_pkg::bus_data_t     reg_rdata,
    input  mbox_bus_pkg::bus_data_t     dataout,
    output mbox_bus_pkg::bus_data_t     rdata,
    output logic                        rsp_valid,
    output logic                        mbox_error
);
    import mbox_bus_pkg::*;
    import mbox_proto_pkg::*;

    logic      rd_accept;
    logic      mask_rdata;
    bus_data_t rd_word;

    assign rd_accept = acc.accept & ~acc.write;

    // buffer data is only visible to a valid user while a command executes
    assign mask_rdata = acc.rd_dataout &
        (~valid_user | ~(state inside {MBOX_EXECUTE_UC, MBOX_EXECUTE_SOC}));

    always_comb begin
        rd_word = acc.rd_dataout ? dataout : reg_rdata;
        if (mask_rdata) rd_word = '0;
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rsp_valid  <= 1'b0;
            mbox_error <= 1'b0;
        end else begin
            rsp_valid  <= rd_accept;
            // the error goes out with the response of the offending access
            mbox_error <= acc.bad;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) rdata <= rd_word;
    end

endmodule

// File: mbox_top.sv
/*
 lock-based mailbox shared by the uc and a soc requester
 request decode, protocol engine, data buffer and response register
 in a row, with req_hold covering the dataout prefetch
*/

`timescale 1ns/100ps

module mbox_top #(
    parameter int MBOX_DEPTH = 64
) (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic                    req_dv,
    input  mbox_bus_pkg::mbox_req_t req,
    output logic                    req_hold,
    output mbox_bus_pkg::bus_data_t rdata,
    output logic                    rsp_valid,
    output logic                    mbox_error,
    output logic                    uc_mbox_data_avail,
    output logic                    soc_mbox_data_avail
);
    import mbox_bus_pkg::*;
    import mbox_proto_pkg::*;

    reg_acc_t    acc;
    mbox_state_e state;
    logic        valid_user;
    logic        buf_we;
    logic        inc_rdptr;
    logic        rst_wrptr;
    logic        rst_rdptr;
    bus_data_t   reg_rdata;
    bus_data_t   dataout;
    logic        prefetch_busy;

    // the requester waits while dataout is being refilled
    assign req_hold = prefetch_busy;

    mbox_req_decode i_req_decode (
        .req_dv   (req_dv),
        .req_hold (req_hold),
        .req      (req),
        .acc      (acc)
    );

    mbox_fsm i_fsm (
        .clk                 (clk),
        .rst_b               (rst_b),
        .acc                 (acc),
        .state               (state),
        .valid_user          (valid_user),
        .buf_we              (buf_we),
        .inc_rdptr           (inc_rdptr),
        .rst_wrptr           (rst_wrptr),
        .rst_rdptr           (rst_rdptr),
        .reg_rdata           (reg_rdata),
        .uc_mbox_data_avail  (uc_mbox_data_avail),
        .soc_mbox_data_avail (soc_mbox_data_avail)
    );

    mbox_buffer #(
        .MBOX_DEPTH (MBOX_DEPTH)
    ) i_buffer (
        .clk           (clk),
        .rst_b         (rst_b),
        .wdata         (acc.wdata),
        .buf_we        (buf_we),
        .inc_rdptr     (inc_rdptr),
        .rst_wrptr     (rst_wrptr),
        .rst_rdptr     (rst_rdptr),
        .dataout       (dataout),
        .prefetch_busy (prefetch_busy)
    );

    mbox_rsp i_rsp (
        .clk        (clk),
        .rst_b      (rst_b),
        .acc        (acc),
        .valid_user (valid_user),
        .state      (state),
        .reg_rdata  (reg_rdata),
        .dataout    (dataout),
        .rdata      (rdata),
        .rsp_valid  (rsp_valid),
        .mbox_error (mbox_error)
    );

endmodule

// File: run.sh
#!/bin/sh
# build the mailbox testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_mbox \
    -f list.f -o tb_mbox_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_mbox_sim > sim.log 2>&1
grep -q "^NO ERRORS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: tb_mbox.sv
/*
 mailbox testbench
 walks one soc command through lock, setup, execute, handback and release,
 then probes the bad-access strobe, all from a table of expected values
*/

`timescale 1ns/100ps

module tb_mbox;
    import mbox_bus_pkg::*;
    import mbox_proto_pkg::*;

    localparam mbox_user_t SOC_USER   = 8'h3a;
    localparam mbox_user_t OTHER_USER = 8'h5c;
    localparam mbox_user_t UC_USER    = 8'h00;
    localparam int         RSP_WAIT   = 4;

    // one table row: the request and what the mailbox should answer
    typedef struct packed {
        mbox_req_t req;
        bus_data_t exp_rdata;
        logic      exp_error;
        logic      exp_uc_avail;
        logic      exp_soc_avail;
    } entry_t;

    logic      clk;
    logic      rst_b;
    logic      req_dv;
    mbox_req_t req;
    logic      req_hold;
    bus_data_t rdata;
    logic      rsp_valid;
    logic      mbox_error;
    logic      uc_mbox_data_avail;
    logic      soc_mbox_data_avail;

    entry_t      table_q[$];
    string       name_q[$];
    logic [31:0] rand_state;
    int          error_count;
    int          cycles;
    int          cycle_limit;

    mbox_top #(
        .MBOX_DEPTH (64)
    ) i_mbox_top (
        .clk                 (clk),
        .rst_b               (rst_b),
        .req_dv              (req_dv),
        .req                 (req),
        .req_hold            (req_hold),
        .rdata               (rdata),
        .rsp_valid           (rsp_valid),
        .mbox_error          (mbox_error),
        .uc_mbox_data_avail  (uc_mbox_data_avail),
        .soc_mbox_data_avail (soc_mbox_data_avail)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    // a run that stalls on req_hold or never answers ends here
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            fail_run("timeout: the request table did not finish in time");
        end
    end

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) begin
            error_count = error_count + 1;
            fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count = error_count + 1;
            fail_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // 32-bit xorshift for the payload words
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // status register layout: state in bits 4:2, command status in bits 1:0
    function automatic bus_data_t status_value(input mbox_state_e st, input mbox_status_e s);
        status_value = {27'd0, st, s};
    endfunction

    task automatic add_entry(input string name, input logic write, input logic soc_req,
                             input mbox_user_t user, input bus_addr_t addr,
                             input bus_data_t wdata, input bus_data_t exp_rdata,
                             input logic exp_error, input logic uc_av, input logic soc_av);
        entry_t e;
        e.req.write     = write;
        e.req.soc_req   = soc_req;
        e.req.user      = user;
        e.req.addr      = addr;
        e.req.wdata     = wdata;
        e.exp_rdata     = exp_rdata;
        e.exp_error     = exp_error;
        e.exp_uc_avail  = uc_av;
        e.exp_soc_avail = soc_av;
        table_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic build_table();
        bus_data_t w [4];
        int        k;
        rand_state = 32'hf958;
        for (k = 0; k < 4; k++) begin
            rand_state = xorshift(rand_state);
            w[k] = rand_state;
        end
        // the soc takes the lock, the uc then finds it taken
        add_entry("soc lock read", 0, 1, SOC_USER, LOCK_OFS, 0, 32'd0, 0, 0, 0);
        add_entry("uc lock read", 0, 0, UC_USER, LOCK_OFS, 0, 32'd1, 0, 0, 0);
        add_entry("soc cmd write", 1, 1, SOC_USER, CMD_OFS, 32'h42, 0, 0, 0, 0);
        add_entry("soc dlen write", 1, 1, SOC_USER, DLEN_OFS, 32'd16, 0, 0, 0, 0);
        for (k = 0; k < 4; k++) begin
            add_entry($sformatf("soc datain %0d", k), 1, 1, SOC_USER, DATAIN_OFS, w[k],
                      0, 0, 0, 0);
        end
        // a soc sender hands the buffer to the uc
        add_entry("soc execute set", 1, 1, SOC_USER, EXECUTE_OFS, 32'd1, 0, 0, 1, 0);
        for (k = 0; k < 4; k++) begin
            // a stranger on the soc side reads while a real word sits in dataout
            if (k == 3) begin
                add_entry("foreign dataout read", 0, 1, OTHER_USER, DATAOUT_OFS, 0,
                          32'd0, 0, 1, 0);
            end
            add_entry($sformatf("uc dataout %0d", k), 0, 0, UC_USER, DATAOUT_OFS, 0,
                      w[k], 0, 1, 0);
        end
        // the stranger cannot write into the buffer either
        add_entry("foreign datain write", 1, 1, OTHER_USER, DATAIN_OFS, ~w[0], 0, 0, 1, 0);
        add_entry("uc status write", 1, 0, UC_USER, STATUS_OFS, 32'(CMD_COMPLETE),
                  0, 0, 1, 0);
        // the first quiet access lets the buffer go back to the soc
        add_entry("soc user read", 0, 1, SOC_USER, USER_OFS, 0, 32'(SOC_USER), 0, 0, 1);
        add_entry("status after swap", 0, 1, SOC_USER, STATUS_OFS, 0,
                  status_value(MBOX_EXECUTE_SOC, CMD_COMPLETE), 0, 0, 1);
        add_entry("soc dataout 0", 0, 1, SOC_USER, DATAOUT_OFS, 0, w[0], 0, 0, 1);
        add_entry("soc execute clear", 1, 1, SOC_USER, EXECUTE_OFS, 32'd0, 0, 0, 0, 0);
        add_entry("status after release", 0, 1, SOC_USER, STATUS_OFS, 0,
                  status_value(MBOX_IDLE, CMD_BUSY), 0, 0, 0);
        add_entry("lock after release", 0, 1, SOC_USER, LOCK_OFS, 0, 32'd0, 0, 0, 0);
        // off-map read and a write to a read-only register
        add_entry("read off map", 0, 1, SOC_USER, 8'h20, 0, 32'd0, 1, 0, 0);
        add_entry("dataout write", 1, 1, SOC_USER, DATAOUT_OFS, 32'h1, 0, 1, 0, 0);
    endtask

    // drive one row, wait out req_hold, then check what came back
    task automatic apply_entry(input int idx);
        entry_t e;
        string  name;
        int     waits;
        e      = table_q[idx];
        name   = name_q[idx];
        req    = e.req;
        req_dv = 1'b1;
        while (req_hold) begin
            @(posedge clk);
            #5;
        end
        @(posedge clk);
        #5;
        req_dv = 1'b0;
        check_flag({name, " error"}, e.exp_error, mbox_error);
        check_flag({name, " uc avail"}, e.exp_uc_avail, uc_mbox_data_avail);
        check_flag({name, " soc avail"}, e.exp_soc_avail, soc_mbox_data_avail);
        if (e.req.write) begin
            check_flag({name, " response"}, 1'b0, rsp_valid);
        end else begin
            waits = 0;
            while (!rsp_valid && waits < RSP_WAIT) begin
                @(posedge clk);
                #5;
                waits = waits + 1;
            end
            if (!rsp_valid) begin
                fail_run($sformatf("no read response for %s", name));
            end
            check_data(name, e.exp_rdata, rdata);
        end
    endtask

    initial begin
        int i;
        rst_b       = 1'b0;
        req_dv      = 1'b0;
        req         = '0;
        error_count = 0;
        cycles      = 0;
        build_table();
        // each row takes one cycle plus at most one cycle of req_hold
        cycle_limit = 2 * table_q.size() + 50;
        repeat (3) @(posedge clk);
        #5;
        rst_b = 1'b1;
        check_flag("reset rsp_valid", 1'b0, rsp_valid);
        check_flag("reset mbox_error", 1'b0, mbox_error);
        check_flag("reset uc avail", 1'b0, uc_mbox_data_avail);
        check_flag("reset soc avail", 1'b0, soc_mbox_data_avail);
        check_flag("reset req_hold", 1'b0, req_hold);
        for (i = 0; i < table_q.size(); i++) begin
            apply_entry(i);
        end
        if (error_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_run("checks failed");
        end
    end

endmodule
